// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run bus_tb, check $(LOG) for the pass line"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module bus_tb -f all.f -Mdir obj_dir
	./obj_dir/Vbus_tb | tee $(LOG)
	@grep -q "^test passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: all.f
+incdir+source
source/bus_pkg.sv
source/ser_fsm.sv
source/ser_beat_counter.sv
source/line_serializer.sv
source/bus_arbiter.sv
source/bus_top.sv
verif/bus_clk_gen.sv
verif/bus_checker.sv
verif/bus_tb.sv

// File: source/bus_arbiter.sv
`default_nettype none
`timescale 1ns/1ps

`include "bus_consts.svh"

module bus_arbiter (
    input  logic               clk_bus,
    input  logic               arst_n,
    input  logic               req_a,
    input  logic               req_b,
    input  logic               release_a,
    input  logic               release_b,
    input  logic               valid_a,
    input  logic               valid_b,
    input  logic [`WORD_W-1:0] word_a,
    input  logic [`WORD_W-1:0] word_b,
    input  logic [`PADR_W-1:0] padr_a,
    input  logic [`PADR_W-1:0] padr_b,
    input  logic [`ID_W-1:0]   dest_a,
    input  logic [`ID_W-1:0]   dest_b,
    input  logic [`ID_W-1:0]   ret_a,
    input  logic [`ID_W-1:0]   ret_b,
    input  bus_pkg::bus_op_e   op_a,
    input  bus_pkg::bus_op_e   op_b,
    input  logic [`SIZE_W-1:0] size_a,
    input  logic [`SIZE_W-1:0] size_b,
    output logic               ack_a,
    output logic               ack_b,
    output logic               grant_a,
    output logic               grant_b,
    output logic               bus_valid,
    output logic [`WORD_W-1:0] bus_data,
    output logic [`PADR_W-1:0] bus_padr,
    output logic [`ID_W-1:0]   bus_dest,
    output logic [`ID_W-1:0]   bus_ret,
    output bus_pkg::bus_op_e   bus_op,
    output logic [`SIZE_W-1:0] bus_size,
    output logic [`ID_W-1:0]   bus_src
);
    import bus_pkg::*;

    logic req_a_q;
    logic req_b_q;
    logic pend_a;
    logic pend_b;
    logic last_b;
    logic idle;
    logic pick_a;
    logic pick_b;

    // round robin, the port that did not own the bus last wins a tie
    assign idle   = !grant_a && !grant_b;
    assign pick_a = idle && pend_a && (!pend_b || last_b);
    assign pick_b = idle && pend_b && !pick_a;

    always_ff @(posedge clk_bus or negedge arst_n) begin
        if (!arst_n) begin
            req_a_q <= 1'b0;
            req_b_q <= 1'b0;
            ack_a   <= 1'b0;
            ack_b   <= 1'b0;
            pend_a  <= 1'b0;
            pend_b  <= 1'b0;
            grant_a <= 1'b0;
            grant_b <= 1'b0;
            last_b  <= 1'b1;
        end else begin
            req_a_q <= req_a;
            req_b_q <= req_b;
            // one ack per rising req
            ack_a   <= req_a && !req_a_q;
            ack_b   <= req_b && !req_b_q;
            if (ack_a) begin
                pend_a <= 1'b1;
            end else if (pick_a) begin
                pend_a <= 1'b0;
            end
            if (ack_b) begin
                pend_b <= 1'b1;
            end else if (pick_b) begin
                pend_b <= 1'b0;
            end
            // grant drops after release, leaving one idle cycle
            if (pick_a) begin
                grant_a <= 1'b1;
                last_b  <= 1'b0;
            end else if (release_a) begin
                grant_a <= 1'b0;
            end
            if (pick_b) begin
                grant_b <= 1'b1;
                last_b  <= 1'b1;
            end else if (release_b) begin
                grant_b <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // bus driver, zeros while nobody sends
    ////////////////////////////////////////////////////////////
    always_comb begin
        bus_valid = 1'b0;
        bus_data  = '0;
        bus_padr  = '0;
        bus_dest  = '0;
        bus_ret   = '0;
        bus_op    = BUS_RD;
        bus_size  = '0;
        bus_src   = '0;
        if (grant_a && valid_a) begin
            bus_valid = 1'b1;
            bus_data  = word_a;
            bus_padr  = padr_a;
            bus_dest  = dest_a;
            bus_ret   = ret_a;
            bus_op    = op_a;
            bus_size  = size_a;
            bus_src   = `ID_W'(0);
        end else if (grant_b && valid_b) begin
            bus_valid = 1'b1;
            bus_data  = word_b;
            bus_padr  = padr_b;
            bus_dest  = dest_b;
            bus_ret   = ret_b;
            bus_op    = op_b;
            bus_size  = size_b;
            bus_src   = `ID_W'(1);
        end
    end

endmodule

`default_nettype wire

// File: source/bus_consts.svh
`ifndef BUS_CONSTS_SVH
`define BUS_CONSTS_SVH

// line held by one serializer, in bits
`define LINE_W 128

// one bus word
`define WORD_W 32

// words per full line
`define BEATS 4

// header field widths
`define PADR_W 15
`define ID_W   4
`define SIZE_W 16

`endif

// File: source/bus_pkg.sv
`default_nettype none

package bus_pkg;

    // serializer sequence
    // free -> request -> wait for grant -> send
    typedef enum logic [1:0] {
        ST_FREE = 2'd0,
        ST_REQ  = 2'd1,
        ST_WAIT = 2'd2,
        ST_SEND = 2'd3
    } ser_state_e;

    // transfer direction carried in the header
    typedef enum logic {
        BUS_RD = 1'b0,
        BUS_WR = 1'b1
    } bus_op_e;

endpackage

`default_nettype wire

// File: source/bus_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "bus_consts.svh"

module bus_top (
    input  logic               clk_bus,
    input  logic               arst_n,
    input  logic               valid_a,
    input  logic [`PADR_W-1:0] padr_a,
    input  logic [`LINE_W-1:0] data_a,
    input  logic [`ID_W-1:0]   dest_a,
    input  logic [`ID_W-1:0]   ret_a,
    input  bus_pkg::bus_op_e   op_a,
    input  logic [`SIZE_W-1:0] size_a,
    output logic               free_a,
    input  logic               valid_b,
    input  logic [`PADR_W-1:0] padr_b,
    input  logic [`LINE_W-1:0] data_b,
    input  logic [`ID_W-1:0]   dest_b,
    input  logic [`ID_W-1:0]   ret_b,
    input  bus_pkg::bus_op_e   op_b,
    input  logic [`SIZE_W-1:0] size_b,
    output logic               free_b,
    output logic               bus_valid,
    output logic [`WORD_W-1:0] bus_data,
    output logic [`PADR_W-1:0] bus_padr,
    output logic [`ID_W-1:0]   bus_dest,
    output logic [`ID_W-1:0]   bus_ret,
    output bus_pkg::bus_op_e   bus_op,
    output logic [`SIZE_W-1:0] bus_size,
    output logic [`ID_W-1:0]   bus_src
);
    import bus_pkg::*;

    // per port links to the arbiter
    logic               ack_a, ack_b, grant_a, grant_b;
    logic               req_a, req_b, release_a, release_b;
    logic               wvalid_a, wvalid_b;
    logic [`WORD_W-1:0] word_a, word_b;
    logic [`PADR_W-1:0] wpadr_a, wpadr_b;
    logic [`ID_W-1:0]   wdest_a, wdest_b, wret_a, wret_b;
    bus_op_e            wop_a, wop_b;
    logic [`SIZE_W-1:0] wsize_a, wsize_b;

    line_serializer u_ser_a (
        .clk_bus (clk_bus), .arst_n (arst_n),
        .valid (valid_a), .padr (padr_a), .data (data_a), .dest (dest_a),
        .ret (ret_a), .op (op_a), .size (size_a), .free (free_a),
        .ack (ack_a), .grant (grant_a), .req (req_a), .bus_release (release_a),
        .word_valid (wvalid_a), .word (word_a), .word_padr (wpadr_a),
        .word_dest (wdest_a), .word_ret (wret_a), .word_op (wop_a), .word_size (wsize_a)
    );

    line_serializer u_ser_b (
        .clk_bus (clk_bus), .arst_n (arst_n),
        .valid (valid_b), .padr (padr_b), .data (data_b), .dest (dest_b),
        .ret (ret_b), .op (op_b), .size (size_b), .free (free_b),
        .ack (ack_b), .grant (grant_b), .req (req_b), .bus_release (release_b),
        .word_valid (wvalid_b), .word (word_b), .word_padr (wpadr_b),
        .word_dest (wdest_b), .word_ret (wret_b), .word_op (wop_b), .word_size (wsize_b)
    );

    bus_arbiter u_arb (
        .clk_bus (clk_bus), .arst_n (arst_n),
        .req_a (req_a), .req_b (req_b), .release_a (release_a), .release_b (release_b),
        .valid_a (wvalid_a), .valid_b (wvalid_b), .word_a (word_a), .word_b (word_b),
        .padr_a (wpadr_a), .padr_b (wpadr_b), .dest_a (wdest_a), .dest_b (wdest_b),
        .ret_a (wret_a), .ret_b (wret_b), .op_a (wop_a), .op_b (wop_b),
        .size_a (wsize_a), .size_b (wsize_b),
        .ack_a (ack_a), .ack_b (ack_b), .grant_a (grant_a), .grant_b (grant_b),
        .bus_valid (bus_valid), .bus_data (bus_data), .bus_padr (bus_padr),
        .bus_dest (bus_dest), .bus_ret (bus_ret), .bus_op (bus_op),
        .bus_size (bus_size), .bus_src (bus_src)
    );

endmodule

`default_nettype wire

// File: source/line_serializer.sv
`default_nettype none
`timescale 1ns/1ps

`include "bus_consts.svh"

module line_serializer (
    input  logic                clk_bus,
    input  logic                arst_n,
    input  logic                valid,
    input  logic [`PADR_W-1:0]  padr,
    input  logic [`LINE_W-1:0]  data,
    input  logic [`ID_W-1:0]    dest,
    input  logic [`ID_W-1:0]    ret,
    input  bus_pkg::bus_op_e    op,
    input  logic [`SIZE_W-1:0]  size,
    output logic                free,
    input  logic                ack,
    input  logic                grant,
    output logic                req,
    output logic                bus_release,
    output logic                word_valid,
    output logic [`WORD_W-1:0]  word,
    output logic [`PADR_W-1:0]  word_padr,
    output logic [`ID_W-1:0]    word_dest,
    output logic [`ID_W-1:0]    word_ret,
    output bus_pkg::bus_op_e    word_op,
    output logic [`SIZE_W-1:0]  word_size
);
    import bus_pkg::*;

    ser_state_e        fsm_state;
    logic              load;
    logic              send;
    logic              last_beat;
    logic [1:0]        beat;
    logic [`LINE_W-1:0] line_q;

    ser_fsm u_fsm (
        .clk_bus     (clk_bus),
        .arst_n      (arst_n),
        .valid       (valid),
        .ack         (ack),
        .grant       (grant),
        .last_beat   (last_beat),
        .state       (fsm_state),
        .free        (free),
        .req         (req),
        .bus_release (bus_release),
        .load        (load),
        .send        (send)
    );

    ser_beat_counter u_cnt (
        .clk_bus   (clk_bus),
        .arst_n    (arst_n),
        .load      (load),
        .advance   (send),
        .size      (size),
        .beat      (beat),
        .last_beat (last_beat)
    );

    ////////////////////////////////////////////////////////////
    // line and header capture on acceptance
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_bus) begin
        if (load) begin
            line_q    <= data;
            word_padr <= padr;
            word_dest <= dest;
            word_ret  <= ret;
            word_op   <= op;
            word_size <= size;
        end
    end

    // word k sits at bits 32k+31..32k
    assign word       = line_q[beat*`WORD_W +: `WORD_W];
    assign word_valid = (fsm_state == ST_SEND);

endmodule

`default_nettype wire

// File: source/ser_beat_counter.sv
`default_nettype none
`timescale 1ns/1ps

`include "bus_consts.svh"

module ser_beat_counter (
    input  logic               clk_bus,
    input  logic               arst_n,
    input  logic               load,
    input  logic               advance,
    input  logic [`SIZE_W-1:0] size,
    output logic [1:0]         beat,
    output logic               last_beat
);
    logic [`SIZE_W-1:0] words_m1;
    logic [1:0]         limit;
    logic [1:0]         last_idx;

    // index of the final word, ceil(size/4) - 1
    // a zero size still moves one word
    assign words_m1 = (size == '0) ? '0 : (size - 1'b1) >> 2;
    assign limit    = (words_m1 > `SIZE_W'(`BEATS - 1)) ? 2'(`BEATS - 1) : words_m1[1:0];

    assign last_beat = (beat == last_idx);

    always_ff @(posedge clk_bus or negedge arst_n) begin
        if (!arst_n) begin
            beat     <= 2'd0;
            last_idx <= 2'd0;
        end else if (load) begin
            beat     <= 2'd0;
            last_idx <= limit;
        end else if (advance) begin
            beat <= beat + 2'd1;
        end
    end

endmodule

`default_nettype wire

// File: source/ser_fsm.sv
`default_nettype none
`timescale 1ns/1ps

module ser_fsm (
    input  logic                  clk_bus,
    input  logic                  arst_n,
    input  logic                  valid,
    input  logic                  ack,
    input  logic                  grant,
    input  logic                  last_beat,
    output bus_pkg::ser_state_e   state,
    output logic                  free,
    output logic                  req,
    output logic                  bus_release,
    output logic                  load,
    output logic                  send
);
    import bus_pkg::*;

    ser_state_e state_nxt;

    assign free        = (state == ST_FREE);
    assign load        = free && valid;
    assign req         = (state == ST_REQ) || (state == ST_WAIT);
    assign send        = (state == ST_SEND);
    assign bus_release = send && last_beat;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_FREE: begin
                if (valid) begin
                    state_nxt = ST_REQ;
                end
            end
            // arbiter has to acknowledge before grant counts
            ST_REQ: begin
                if (ack) begin
                    state_nxt = ST_WAIT;
                end
            end
            ST_WAIT: begin
                if (grant) begin
                    state_nxt = ST_SEND;
                end
            end
            ST_SEND: begin
                if (last_beat) begin
                    state_nxt = ST_FREE;
                end
            end
            default: state_nxt = ST_FREE;
        endcase
    end

    always_ff @(posedge clk_bus or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_FREE;
        end else begin
            state <= state_nxt;
        end
    end

endmodule

`default_nettype wire

// File: verif/bus_checker.sv
`default_nettype none
`timescale 1ns/1ps

module bus_checker (
    input logic clk_bus,
    input logic arst_n,
    input logic req_a,
    input logic req_b,
    input logic ack_a,
    input logic ack_b,
    input logic grant_a,
    input logic grant_b,
    input logic bus_valid
);

    // only one owner of the bus
    a_one_grant: assert property (@(posedge clk_bus) disable iff (!arst_n)
        !(grant_a && grant_b))
        else $error("grant_a and grant_b high in the same cycle");

    a_valid_owner: assert property (@(posedge clk_bus) disable iff (!arst_n)
        bus_valid |-> (grant_a ^ grant_b))
        else $error("bus_valid without exactly one grant");

    ////////////////////////////////////////////////////////////
    // ack is a single pulse behind req
    ////////////////////////////////////////////////////////////
    a_ack_a_pulse: assert property (@(posedge clk_bus) disable iff (!arst_n)
        ack_a |=> !ack_a)
        else $error("ack_a longer than one cycle");

    a_ack_b_pulse: assert property (@(posedge clk_bus) disable iff (!arst_n)
        ack_b |=> !ack_b)
        else $error("ack_b longer than one cycle");

    a_ack_a_req: assert property (@(posedge clk_bus) disable iff (!arst_n)
        ack_a |-> $past(req_a))
        else $error("ack_a without a preceding req_a");

    a_ack_b_req: assert property (@(posedge clk_bus) disable iff (!arst_n)
        ack_b |-> $past(req_b))
        else $error("ack_b without a preceding req_b");

endmodule

bind bus_arbiter bus_checker u_checker (
    .clk_bus   (clk_bus),
    .arst_n    (arst_n),
    .req_a     (req_a),
    .req_b     (req_b),
    .ack_a     (ack_a),
    .ack_b     (ack_b),
    .grant_a   (grant_a),
    .grant_b   (grant_b),
    .bus_valid (bus_valid)
);

`default_nettype wire

// File: verif/bus_clk_gen.sv
`default_nettype none
`timescale 1ns/1ps

module bus_clk_gen #(
    parameter int PERIOD_NS = 4
) (
    output logic clk
);
    // free running, starts low
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

// File: verif/bus_tb.sv
`default_nettype none
`timescale 1ns/1ps

`include "bus_consts.svh"

module bus_tb;
    import bus_pkg::*;

    localparam int TIMEOUT = 200;
    localparam int ENTRIES = 8;

    // ports: bit 0 is port a, bit 1 is port b
    typedef struct packed {
        logic [1:0]         ports;
        logic [`SIZE_W-1:0] size;
        bus_op_e            op;
        logic [`ID_W-1:0]   dest;
        logic [`ID_W-1:0]   ret;
        logic [`PADR_W-1:0] padr;
    } entry_t;

    logic               clk_bus;
    logic               arst_n;
    logic               valid_a;
    logic [`PADR_W-1:0] padr_a;
    logic [`LINE_W-1:0] data_a;
    logic [`ID_W-1:0]   dest_a;
    logic [`ID_W-1:0]   ret_a;
    bus_op_e            op_a;
    logic [`SIZE_W-1:0] size_a;
    logic               free_a;
    logic               valid_b;
    logic [`PADR_W-1:0] padr_b;
    logic [`LINE_W-1:0] data_b;
    logic [`ID_W-1:0]   dest_b;
    logic [`ID_W-1:0]   ret_b;
    bus_op_e            op_b;
    logic [`SIZE_W-1:0] size_b;
    logic               free_b;
    logic               bus_valid;
    logic [`WORD_W-1:0] bus_data;
    logic [`PADR_W-1:0] bus_padr;
    logic [`ID_W-1:0]   bus_dest;
    logic [`ID_W-1:0]   bus_ret;
    bus_op_e            bus_op;
    logic [`SIZE_W-1:0] bus_size;
    logic [`ID_W-1:0]   bus_src;

    entry_t      table_q [ENTRIES];
    logic [31:0] lfsr;
    int          last_owner;

    bus_clk_gen #(.PERIOD_NS(4)) u_clk (.clk(clk_bus));

    bus_top UUT (
        .clk_bus (clk_bus), .arst_n (arst_n),
        .valid_a (valid_a), .padr_a (padr_a), .data_a (data_a), .dest_a (dest_a),
        .ret_a (ret_a), .op_a (op_a), .size_a (size_a), .free_a (free_a),
        .valid_b (valid_b), .padr_b (padr_b), .data_b (data_b), .dest_b (dest_b),
        .ret_b (ret_b), .op_b (op_b), .size_b (size_b), .free_b (free_b),
        .bus_valid (bus_valid), .bus_data (bus_data), .bus_padr (bus_padr),
        .bus_dest (bus_dest), .bus_ret (bus_ret), .bus_op (bus_op),
        .bus_size (bus_size), .bus_src (bus_src)
    );

    ////////////////////////////////////////////////////////////
    // failure and compare tasks
    ////////////////////////////////////////////////////////////
    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("test failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_word(input string name, input logic [`WORD_W-1:0] got,
                              input logic [`WORD_W-1:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("error %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_op(input string name, input bus_op_e got, input bus_op_e exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("error %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_id(input string name, input logic [`ID_W-1:0] got,
                            input logic [`ID_W-1:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("error %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_padr(input string name, input logic [`PADR_W-1:0] got,
                              input logic [`PADR_W-1:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("error %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_size(input string name, input logic [`SIZE_W-1:0] got,
                              input logic [`SIZE_W-1:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("error %s: got %h expected %h", name, got, exp));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////
    // galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic fill_line(output logic [`LINE_W-1:0] line);
        for (int i = 0; i < `LINE_W; i++) begin
            lfsr    = lfsr_step(lfsr);
            line[i] = lfsr[0];
        end
    endtask

    // ceil(size / 4), at least one word, at most a full line
    function automatic int expected_beats(input logic [`SIZE_W-1:0] size);
        int n;
        n = (int'(size) + 3) / 4;
        if (n < 1) begin
            n = 1;
        end
        if (n > `BEATS) begin
            n = `BEATS;
        end
        return n;
    endfunction

    function automatic logic port_free(input int port);
        return (port == 0) ? free_a : free_b;
    endfunction

    task automatic wait_free(input int port);
        int n;
        n = 0;
        while (!port_free(port)) begin
            if (n == TIMEOUT) begin
                stop_with_failure("timeout while waiting for a port to become free");
            end
            @(negedge clk_bus);
            n++;
        end
    endtask

    // bus monitor for one transfer from the given port
    task automatic collect_transfer(input int port, input logic [`LINE_W-1:0] line,
                                    input entry_t e);
        int n;
        int k;
        int beats;
        n     = 0;
        beats = expected_beats(e.size);
        while (!bus_valid) begin
            if (port_free(port)) begin
                stop_with_failure("port became free before its words reached the bus");
            end
            if (n == TIMEOUT) begin
                stop_with_failure("timeout while waiting for bus_valid");
            end
            @(negedge clk_bus);
            n++;
        end
        for (k = 0; k < beats; k++) begin
            if (!bus_valid) begin
                stop_with_failure("bus_valid dropped in the middle of a transfer");
            end
            if (port_free(port)) begin
                stop_with_failure("port is free while its transfer is on the bus");
            end
            check_id("bus_src", bus_src, `ID_W'(port));
            check_word("bus_data", bus_data, line[k*`WORD_W +: `WORD_W]);
            check_padr("bus_padr", bus_padr, e.padr);
            check_id("bus_dest", bus_dest, e.dest);
            check_id("bus_ret", bus_ret, e.ret);
            check_op("bus_op", bus_op, e.op);
            check_size("bus_size", bus_size, e.size);
            @(negedge clk_bus);
        end
        if (bus_valid) begin
            stop_with_failure("bus still busy after the last word of a transfer");
        end
        if (!port_free(port)) begin
            stop_with_failure("port did not return to free after its transfer");
        end
        last_owner = port;
    endtask

    task automatic run_entry(input entry_t e);
        logic [`LINE_W-1:0] line_a;
        logic [`LINE_W-1:0] line_b;
        int                 first;
        if (e.ports[0]) begin
            wait_free(0);
        end
        if (e.ports[1]) begin
            wait_free(1);
        end
        fill_line(line_a);
        fill_line(line_b);
        valid_a = e.ports[0];
        valid_b = e.ports[1];
        data_a  = line_a;
        data_b  = line_b;
        padr_a  = e.padr;
        padr_b  = e.padr;
        dest_a  = e.dest;
        dest_b  = e.dest;
        ret_a   = e.ret;
        ret_b   = e.ret;
        op_a    = e.op;
        op_b    = e.op;
        size_a  = e.size;
        size_b  = e.size;
        @(negedge clk_bus);
        valid_a = 1'b0;
        valid_b = 1'b0;
        if ((e.ports[0] && free_a) || (e.ports[1] && free_b)) begin
            stop_with_failure("port still free after its line was accepted");
        end
        // with both pending, the port that did not own the bus last goes first
        if (e.ports == 2'b11) begin
            first = (last_owner == 1) ? 0 : 1;
        end else begin
            first = e.ports[0] ? 0 : 1;
        end
        collect_transfer(first, (first == 0) ? line_a : line_b, e);
        if (e.ports == 2'b11) begin
            collect_transfer(1 - first, (first == 0) ? line_b : line_a, e);
        end
    endtask

    task automatic load_table();
        table_q[0] = '{2'b01, 16'd16, BUS_WR, 4'h3, 4'h5, 15'h1234};
        table_q[1] = '{2'b10, 16'd1,  BUS_RD, 4'h7, 4'h2, 15'h0040};
        table_q[2] = '{2'b01, 16'd4,  BUS_WR, 4'h1, 4'hE, 15'h7FFC};
        table_q[3] = '{2'b10, 16'd5,  BUS_RD, 4'hA, 4'h0, 15'h2000};
        table_q[4] = '{2'b11, 16'd12, BUS_WR, 4'h6, 4'h9, 15'h0ABC};
        table_q[5] = '{2'b01, 16'd0,  BUS_RD, 4'hF, 4'h4, 15'h3333};
        table_q[6] = '{2'b11, 16'd20, BUS_WR, 4'h2, 4'hC, 15'h5A5A};
        table_q[7] = '{2'b11, 16'd16, BUS_RD, 4'h8, 4'h1, 15'h0001};
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        arst_n     = 1'b0;
        valid_a    = 1'b0;
        padr_a     = '0;
        data_a     = '0;
        dest_a     = '0;
        ret_a      = '0;
        op_a       = BUS_RD;
        size_a     = '0;
        valid_b    = 1'b0;
        padr_b     = '0;
        data_b     = '0;
        dest_b     = '0;
        ret_b      = '0;
        op_b       = BUS_RD;
        size_b     = '0;
        lfsr       = 32'd73124;
        last_owner = 1;
        load_table();
        repeat (4) @(posedge clk_bus);
        @(negedge clk_bus);
        arst_n = 1'b1;
        // idle bus before the first request
        repeat (3) begin
            @(negedge clk_bus);
            if (!free_a || !free_b) begin
                stop_with_failure("a port is not free after reset");
            end
            if (bus_valid) begin
                stop_with_failure("bus_valid high before any request");
            end
        end
        for (int i = 0; i < ENTRIES; i++) begin
            run_entry(table_q[i]);
        end
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire
